//--- src/glb_pkg.sv
// Tile widths, register map addresses and shared vector types
package glb_pkg;

    // ####################################################################
    // Widths
    // ####################################################################
    localparam int CGRA_DATA_WIDTH  = 16;
    localparam int CGRA_PER_GLB     = 2;
    localparam int BANK_ADDR_WIDTH  = 8;
    localparam int BANK_DEPTH       = 1 << BANK_ADDR_WIDTH;
    // One extra bit so a full bank length fits
    localparam int WORD_COUNT_WIDTH = BANK_ADDR_WIDTH + 1;
    localparam int CFG_ADDR_WIDTH   = 3;
    localparam int CFG_DATA_WIDTH   = 16;

    // ####################################################################
    // Shared types
    // ####################################################################
    typedef logic [CGRA_DATA_WIDTH-1:0]  cgra_data_t;
    typedef logic [BANK_ADDR_WIDTH-1:0]  bank_addr_t;
    typedef logic [WORD_COUNT_WIDTH-1:0] word_count_t;
    typedef logic [CGRA_PER_GLB-1:0]     col_mask_t;
    typedef logic [CFG_ADDR_WIDTH-1:0]   cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0]   cfg_data_t;

    // ####################################################################
    // Register map
    // ####################################################################
    localparam cfg_addr_t REG_G2F_MUX        = 3'd0;
    localparam cfg_addr_t REG_F2G_MUX        = 3'd1;
    localparam cfg_addr_t REG_SOFT_RESET_MUX = 3'd2;
    localparam cfg_addr_t REG_G2F_START_ADDR = 3'd3;
    // Write starts the g2f DMA
    localparam cfg_addr_t REG_G2F_NUM_WORDS  = 3'd4;
    localparam cfg_addr_t REG_F2G_START_ADDR = 3'd5;
    // Write starts the f2g DMA
    localparam cfg_addr_t REG_F2G_NUM_WORDS  = 3'd6;

endpackage

//--- src/glb_cfg_regs.sv
// Configuration registers with read-back and DMA start pulses
`timescale 1ns/1ps

module glb_cfg_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_wr_en,
    input  glb_pkg::cfg_addr_t   cfg_addr,
    input  glb_pkg::cfg_data_t   cfg_wr_data,
    output glb_pkg::cfg_data_t   cfg_rd_data,
    output glb_pkg::col_mask_t   g2f_mux,
    output glb_pkg::col_mask_t   f2g_mux,
    output glb_pkg::col_mask_t   soft_reset_mux,
    output glb_pkg::bank_addr_t  g2f_start_addr,
    output glb_pkg::word_count_t g2f_num_words,
    output logic                 g2f_start,
    output glb_pkg::bank_addr_t  f2g_start_addr,
    output glb_pkg::word_count_t f2g_num_words,
    output logic                 f2g_start
);
    import glb_pkg::*;

    // Write decode, each field keeps only its own width
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            g2f_mux        <= '0;
            f2g_mux        <= '0;
            soft_reset_mux <= '0;
            g2f_start_addr <= '0;
            g2f_num_words  <= '0;
            f2g_start_addr <= '0;
            f2g_num_words  <= '0;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                REG_G2F_MUX:        g2f_mux        <= cfg_wr_data[CGRA_PER_GLB-1:0];
                REG_F2G_MUX:        f2g_mux        <= cfg_wr_data[CGRA_PER_GLB-1:0];
                REG_SOFT_RESET_MUX: soft_reset_mux <= cfg_wr_data[CGRA_PER_GLB-1:0];
                REG_G2F_START_ADDR: g2f_start_addr <= cfg_wr_data[BANK_ADDR_WIDTH-1:0];
                REG_G2F_NUM_WORDS:  g2f_num_words  <= cfg_wr_data[WORD_COUNT_WIDTH-1:0];
                REG_F2G_START_ADDR: f2g_start_addr <= cfg_wr_data[BANK_ADDR_WIDTH-1:0];
                REG_F2G_NUM_WORDS:  f2g_num_words  <= cfg_wr_data[WORD_COUNT_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // Start pulses, high for the cycle after the length write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            g2f_start <= 1'b0;
            f2g_start <= 1'b0;
        end else begin
            g2f_start <= cfg_wr_en && (cfg_addr == REG_G2F_NUM_WORDS);
            f2g_start <= cfg_wr_en && (cfg_addr == REG_F2G_NUM_WORDS);
        end
    end

    // Read-back, zero extended; unused addresses read zero
    always_comb begin
        case (cfg_addr)
            REG_G2F_MUX:        cfg_rd_data = cfg_data_t'(g2f_mux);
            REG_F2G_MUX:        cfg_rd_data = cfg_data_t'(f2g_mux);
            REG_SOFT_RESET_MUX: cfg_rd_data = cfg_data_t'(soft_reset_mux);
            REG_G2F_START_ADDR: cfg_rd_data = cfg_data_t'(g2f_start_addr);
            REG_G2F_NUM_WORDS:  cfg_rd_data = cfg_data_t'(g2f_num_words);
            REG_F2G_START_ADDR: cfg_rd_data = cfg_data_t'(f2g_start_addr);
            REG_F2G_NUM_WORDS:  cfg_rd_data = cfg_data_t'(f2g_num_words);
            default:            cfg_rd_data = '0;
        endcase
    end

endmodule

//--- src/glb_bank_mem.sv
// Single bank memory with registered read and shared write port
`timescale 1ns/1ps

module glb_bank_mem (
    input  logic                clk,
    input  logic                rd_en,
    input  glb_pkg::bank_addr_t rd_addr,
    output glb_pkg::cgra_data_t rd_data,
    input  logic                dma_wr_en,
    input  glb_pkg::bank_addr_t dma_wr_addr,
    input  glb_pkg::cgra_data_t dma_wr_data,
    input  logic                host_wr_en,
    input  glb_pkg::bank_addr_t host_wr_addr,
    input  glb_pkg::cgra_data_t host_wr_data
);
    import glb_pkg::*;

    cgra_data_t mem [BANK_DEPTH];

    logic       wr_en;
    bank_addr_t wr_addr;
    cgra_data_t wr_data;

    // DMA write has priority over the host
    assign wr_en   = dma_wr_en || host_wr_en;
    assign wr_addr = dma_wr_en ? dma_wr_addr : host_wr_addr;
    assign wr_data = dma_wr_en ? dma_wr_data : host_wr_data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- src/glb_g2f_dma.sv
// Read DMA streaming a block of bank words toward the array
`timescale 1ns/1ps

module glb_g2f_dma (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  glb_pkg::bank_addr_t  start_addr,
    input  glb_pkg::word_count_t num_words,
    output logic                 rd_en,
    output glb_pkg::bank_addr_t  rd_addr,
    input  glb_pkg::cgra_data_t  rd_data,
    output glb_pkg::cgra_data_t  strm_data,
    output logic                 strm_valid,
    output logic                 done
);
    import glb_pkg::*;

    typedef enum logic {
        G2F_IDLE,
        G2F_STREAM
    } state_t;

    state_t      state;
    bank_addr_t  addr;
    word_count_t remaining;
    logic        rd_last;
    logic        valid_last;

    // One read per cycle while streaming
    assign rd_en   = (state == G2F_STREAM);
    assign rd_addr = addr;
    assign rd_last = rd_en && (remaining == word_count_t'(1));

    // ####################################################################
    // Address and length counters
    // ####################################################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= G2F_IDLE;
            addr      <= '0;
            remaining <= '0;
        end else begin
            case (state)
                G2F_IDLE: begin
                    // Zero length never leaves idle
                    if (start && (num_words != '0)) begin
                        state     <= G2F_STREAM;
                        addr      <= start_addr;
                        remaining <= num_words;
                    end
                end
                G2F_STREAM: begin
                    addr      <= addr + bank_addr_t'(1);
                    remaining <= remaining - word_count_t'(1);
                    if (rd_last) begin
                        state <= G2F_IDLE;
                    end
                end
                default: state <= G2F_IDLE;
            endcase
        end
    end

    // Valid trails the read by the memory latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strm_valid <= 1'b0;
            valid_last <= 1'b0;
            done       <= 1'b0;
        end else begin
            strm_valid <= rd_en;
            valid_last <= rd_last;
            done       <= valid_last ||
                          ((state == G2F_IDLE) && start && (num_words == '0));
        end
    end

    assign strm_data = strm_valid ? rd_data : '0;

endmodule

//--- src/glb_f2g_dma.sv
// Write DMA storing a block of stream words into the bank
`timescale 1ns/1ps

module glb_f2g_dma (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  glb_pkg::bank_addr_t  start_addr,
    input  glb_pkg::word_count_t num_words,
    input  glb_pkg::cgra_data_t  strm_data,
    input  logic                 strm_valid,
    output logic                 wr_en,
    output glb_pkg::bank_addr_t  wr_addr,
    output glb_pkg::cgra_data_t  wr_data,
    output logic                 done
);
    import glb_pkg::*;

    typedef enum logic {
        F2G_IDLE,
        F2G_ARMED
    } state_t;

    state_t      state;
    bank_addr_t  base;
    word_count_t total;
    word_count_t count;

    // Valids outside the armed state are dropped
    assign wr_en   = (state == F2G_ARMED) && strm_valid;
    assign wr_addr = base + count[BANK_ADDR_WIDTH-1:0];
    assign wr_data = strm_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= F2G_IDLE;
            base  <= '0;
            total <= '0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                F2G_IDLE: begin
                    if (start) begin
                        base  <= start_addr;
                        total <= num_words;
                        count <= '0;
                        if (num_words == '0) begin
                            done <= 1'b1;
                        end else begin
                            state <= F2G_ARMED;
                        end
                    end
                end
                F2G_ARMED: begin
                    if (strm_valid) begin
                        count <= count + word_count_t'(1);
                        // Last word accepted
                        if (count + word_count_t'(1) == total) begin
                            state <= F2G_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= F2G_IDLE;
            endcase
        end
    end

endmodule

//--- src/glb_strm_mux.sv
// Column stream fan-out, f2g column select and soft-reset routing
`timescale 1ns/1ps

module glb_strm_mux (
    input  logic                clk,
    input  logic                reset,
    input  glb_pkg::cgra_data_t g2f_dma_data,
    input  logic                g2f_dma_valid,
    output glb_pkg::cgra_data_t stream_data_g2f       [glb_pkg::CGRA_PER_GLB],
    output logic                stream_data_valid_g2f [glb_pkg::CGRA_PER_GLB],
    output glb_pkg::cgra_data_t f2g_dma_data,
    output logic                f2g_dma_valid,
    input  glb_pkg::cgra_data_t stream_data_f2g       [glb_pkg::CGRA_PER_GLB],
    input  logic                stream_data_valid_f2g [glb_pkg::CGRA_PER_GLB],
    input  logic                cgra_soft_reset,
    input  glb_pkg::col_mask_t  g2f_mux,
    input  glb_pkg::col_mask_t  f2g_mux,
    input  glb_pkg::col_mask_t  soft_reset_mux
);
    import glb_pkg::*;

    logic soft_reset_d1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            soft_reset_d1 <= 1'b0;
        end else begin
            soft_reset_d1 <= cgra_soft_reset;
        end
    end

    // ####################################################################
    // g2f fan-out
    // ####################################################################
    always_comb begin
        for (int i = 0; i < CGRA_PER_GLB; i++) begin
            stream_data_g2f[i] = g2f_mux[i] ? g2f_dma_data : '0;
            // Soft reset takes over the valid, data still follows g2f_mux
            if (soft_reset_mux[i]) begin
                stream_data_valid_g2f[i] = soft_reset_d1;
            end else begin
                stream_data_valid_g2f[i] = g2f_mux[i] && g2f_dma_valid;
            end
        end
    end

    // f2g select, highest set column wins
    always_comb begin
        f2g_dma_data  = '0;
        f2g_dma_valid = 1'b0;
        for (int i = 0; i < CGRA_PER_GLB; i++) begin
            if (f2g_mux[i]) begin
                f2g_dma_data  = stream_data_f2g[i];
                f2g_dma_valid = stream_data_valid_f2g[i];
            end
        end
    end

endmodule

//--- src/glb_tile.sv
// Global buffer tile top with registers, bank, DMAs and stream mux
`timescale 1ns/1ps

module glb_tile (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_wr_en,
    input  glb_pkg::cfg_addr_t  cfg_addr,
    input  glb_pkg::cfg_data_t  cfg_wr_data,
    output glb_pkg::cfg_data_t  cfg_rd_data,
    input  logic                mem_wr_en,
    input  glb_pkg::bank_addr_t mem_wr_addr,
    input  glb_pkg::cgra_data_t mem_wr_data,
    input  logic                cgra_soft_reset,
    output glb_pkg::cgra_data_t stream_data_g2f       [glb_pkg::CGRA_PER_GLB],
    output logic                stream_data_valid_g2f [glb_pkg::CGRA_PER_GLB],
    input  glb_pkg::cgra_data_t stream_data_f2g       [glb_pkg::CGRA_PER_GLB],
    input  logic                stream_data_valid_f2g [glb_pkg::CGRA_PER_GLB],
    output logic                g2f_done,
    output logic                f2g_done
);
    import glb_pkg::*;

    col_mask_t   g2f_mux, f2g_mux, soft_reset_mux;
    bank_addr_t  g2f_start_addr, f2g_start_addr;
    word_count_t g2f_num_words, f2g_num_words;
    logic        g2f_start, f2g_start;

    // Bank ports
    logic        rd_en, wr_en;
    bank_addr_t  rd_addr, wr_addr;
    cgra_data_t  rd_data, wr_data;

    // DMA side of the mux
    cgra_data_t  g2f_dma_data, f2g_dma_data;
    logic        g2f_dma_valid, f2g_dma_valid;

    glb_cfg_regs u_cfg_regs (
        .clk(clk), .reset(reset),
        .cfg_wr_en(cfg_wr_en), .cfg_addr(cfg_addr),
        .cfg_wr_data(cfg_wr_data), .cfg_rd_data(cfg_rd_data),
        .g2f_mux(g2f_mux), .f2g_mux(f2g_mux), .soft_reset_mux(soft_reset_mux),
        .g2f_start_addr(g2f_start_addr), .g2f_num_words(g2f_num_words),
        .g2f_start(g2f_start),
        .f2g_start_addr(f2g_start_addr), .f2g_num_words(f2g_num_words),
        .f2g_start(f2g_start)
    );

    glb_bank_mem u_bank_mem (
        .clk(clk),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .dma_wr_en(wr_en), .dma_wr_addr(wr_addr), .dma_wr_data(wr_data),
        .host_wr_en(mem_wr_en), .host_wr_addr(mem_wr_addr), .host_wr_data(mem_wr_data)
    );

    glb_g2f_dma u_g2f_dma (
        .clk(clk), .reset(reset),
        .start(g2f_start), .start_addr(g2f_start_addr), .num_words(g2f_num_words),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .strm_data(g2f_dma_data), .strm_valid(g2f_dma_valid), .done(g2f_done)
    );

    glb_f2g_dma u_f2g_dma (
        .clk(clk), .reset(reset),
        .start(f2g_start), .start_addr(f2g_start_addr), .num_words(f2g_num_words),
        .strm_data(f2g_dma_data), .strm_valid(f2g_dma_valid),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .done(f2g_done)
    );

    glb_strm_mux u_strm_mux (
        .clk(clk), .reset(reset),
        .g2f_dma_data(g2f_dma_data), .g2f_dma_valid(g2f_dma_valid),
        .stream_data_g2f(stream_data_g2f), .stream_data_valid_g2f(stream_data_valid_g2f),
        .f2g_dma_data(f2g_dma_data), .f2g_dma_valid(f2g_dma_valid),
        .stream_data_f2g(stream_data_f2g), .stream_data_valid_f2g(stream_data_valid_f2g),
        .cgra_soft_reset(cgra_soft_reset),
        .g2f_mux(g2f_mux), .f2g_mux(f2g_mux), .soft_reset_mux(soft_reset_mux)
    );

endmodule

//--- dv/glb_tile_tb.sv
// Tile testbench with a bank model, random stimulus and typed compare tasks
`timescale 1ns/1ps

module glb_tile_tb;
    import glb_pkg::*;

    // Tests take under 1000 cycles
    localparam int TIMEOUT_CYCLES = 2500;

    logic       clk;
    logic       reset;
    logic       cfg_wr_en;
    cfg_addr_t  cfg_addr;
    cfg_data_t  cfg_wr_data;
    cfg_data_t  cfg_rd_data;
    logic       mem_wr_en;
    bank_addr_t mem_wr_addr;
    cgra_data_t mem_wr_data;
    logic       cgra_soft_reset;
    cgra_data_t stream_data_g2f       [CGRA_PER_GLB];
    logic       stream_data_valid_g2f [CGRA_PER_GLB];
    cgra_data_t stream_data_f2g       [CGRA_PER_GLB];
    logic       stream_data_valid_f2g [CGRA_PER_GLB];
    logic       g2f_done;
    logic       f2g_done;

    // Bank model, pending g2f words and soft reset history
    cgra_data_t model_mem [BANK_DEPTH];
    cgra_data_t exp_q [$];
    logic       sr_prev;
    bit         sr_random;
    integer     seed;
    int         cycles;
    int         data_errs, valid_errs, cfg_errs, mask_errs, other_errs;

    // Bits each register keeps per address
    cfg_data_t  field_mask [8] = '{16'h0003, 16'h0003, 16'h0003, 16'h00ff,
                                   16'h01ff, 16'h00ff, 16'h01ff, 16'h0000};

    glb_tile DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ####################################################################
    // Compare tasks
    // ####################################################################
    task automatic check_data(input string name, input cgra_data_t expected,
                              input cgra_data_t actual);
        if (actual !== expected) begin
            data_errs++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            valid_errs++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_cfg(input string name, input cfg_data_t expected,
                             input cfg_data_t actual);
        if (actual !== expected) begin
            cfg_errs++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_mask(input string name, input col_mask_t expected,
                              input col_mask_t actual);
        if (actual !== expected) begin
            mask_errs++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        sr_prev = cgra_soft_reset;
        if (sr_random) begin
            r = next_random();
            cgra_soft_reset = r[0];
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        cfg_wr_en   = 1'b1;
        cfg_addr    = addr;
        cfg_wr_data = data;
        next_cycle();
        cfg_wr_en   = 1'b0;
    endtask

    // Mask registers compare the mask field and the zero upper bits apart
    task automatic read_check(input cfg_addr_t addr, input cfg_data_t expected);
        cfg_addr = addr;
        @(negedge clk);
        if (addr <= REG_SOFT_RESET_MUX) begin
            check_mask($sformatf("cfg_rd_data mask[reg %0d]", addr),
                       expected[CGRA_PER_GLB-1:0], cfg_rd_data[CGRA_PER_GLB-1:0]);
            check_cfg($sformatf("cfg_rd_data upper bits[reg %0d]", addr),
                      expected >> CGRA_PER_GLB, cfg_rd_data >> CGRA_PER_GLB);
        end else begin
            check_cfg($sformatf("cfg_rd_data[reg %0d]", addr), expected, cfg_rd_data);
        end
        next_cycle();
    endtask

    // ####################################################################
    // g2f block checked on every column each cycle from the start pulse
    // ####################################################################
    task automatic run_g2f(input bank_addr_t start, input int n, input col_mask_t mask,
                           input col_mask_t sr_mask);
        cgra_data_t w;
        logic       in_win;
        logic       exp_done;
        string      dname;
        string      vname;
        for (int k = 0; k < n; k++) begin
            exp_q.push_back(model_mem[bank_addr_t'(start + k)]);
        end
        cfg_write(REG_G2F_MUX, cfg_data_t'(mask));
        cfg_write(REG_SOFT_RESET_MUX, cfg_data_t'(sr_mask));
        cfg_write(REG_G2F_START_ADDR, cfg_data_t'(start));
        cfg_write(REG_G2F_NUM_WORDS, cfg_data_t'(n));
        // Start pulse cycle is j = 0 and the first word comes at j = 2
        for (int j = 0; j <= n + 2; j++) begin
            @(negedge clk);
            in_win   = (j >= 2) && (j < n + 2);
            exp_done = (n == 0) ? (j == 1) : (j == n + 2);
            w = '0;
            if (in_win) begin
                w = exp_q.pop_front();
            end
            for (int c = 0; c < CGRA_PER_GLB; c++) begin
                dname = $sformatf("stream_data_g2f[%0d]", c);
                vname = $sformatf("stream_data_valid_g2f[%0d]", c);
                if (in_win || !mask[c]) begin
                    check_data(dname, mask[c] ? w : '0, stream_data_g2f[c]);
                end
                if (sr_mask[c]) begin
                    check_valid(vname, sr_prev, stream_data_valid_g2f[c]);
                end else if (stream_data_valid_g2f[c] && !(mask[c] && in_win)) begin
                    other_errs++;
                    $display("Column %0d valid at %0t with no expected word", c, $time);
                end else begin
                    check_valid(vname, mask[c] && in_win, stream_data_valid_g2f[c]);
                end
            end
            if (g2f_done !== exp_done) begin
                other_errs++;
                $display("g2f_done wrong at %0t, %0d cycles after start", $time, j);
            end
            next_cycle();
        end
        read_check(REG_G2F_NUM_WORDS, cfg_data_t'(n));
    endtask

    // Selected column sends words with gaps while the other sends garbage
    task automatic run_f2g(input bank_addr_t start, input int n, input int col);
        logic [31:0] r;
        int          accepted;
        accepted = 0;
        cfg_write(REG_F2G_MUX, cfg_data_t'(1 << col));
        cfg_write(REG_F2G_START_ADDR, cfg_data_t'(start));
        cfg_write(REG_F2G_NUM_WORDS, cfg_data_t'(n));
        // DMA arms at the end of the start pulse cycle
        next_cycle();
        while (accepted < n) begin
            r = next_random();
            stream_data_valid_f2g[col]     = (r[1:0] != 2'b00);
            stream_data_f2g[col]           = r[31:16];
            stream_data_valid_f2g[1 - col] = r[2];
            stream_data_f2g[1 - col]       = r[15:0];
            if (r[1:0] != 2'b00) begin
                model_mem[bank_addr_t'(start + accepted)] = r[31:16];
                accepted++;
            end
            @(negedge clk);
            if (f2g_done) begin
                other_errs++;
                $display("f2g_done pulsed early at %0t after %0d words", $time, accepted);
            end
            next_cycle();
        end
        // Valid sent after the block ends is dropped in idle
        r = next_random();
        stream_data_valid_f2g[col]     = 1'b1;
        stream_data_f2g[col]           = r[15:0];
        stream_data_valid_f2g[1 - col] = 1'b0;
        @(negedge clk);
        if (f2g_done !== 1'b1) begin
            other_errs++;
            $display("f2g_done missing at %0t after %0d words", $time, n);
        end
        next_cycle();
        stream_data_valid_f2g[col] = 1'b0;
        read_check(REG_F2G_NUM_WORDS, cfg_data_t'(n));
    endtask

    initial begin
        logic [31:0] r;
        cfg_data_t   wr_vals [8];
        int          n;
        clk             = 1'b0;
        reset           = 1'b1;
        cfg_wr_en       = 1'b0;
        cfg_addr        = '0;
        cfg_wr_data     = '0;
        mem_wr_en       = 1'b0;
        mem_wr_addr     = '0;
        mem_wr_data     = '0;
        cgra_soft_reset = 1'b0;
        for (int c = 0; c < CGRA_PER_GLB; c++) begin
            stream_data_f2g[c]       = '0;
            stream_data_valid_f2g[c] = 1'b0;
        end
        seed      = 12378;
        sr_random = 1'b0;
        sr_prev   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register read-back with zero lengths so no stream runs
        for (int a = 0; a < 8; a++) begin
            r = next_random();
            wr_vals[a] = r[15:0];
            if (cfg_addr_t'(a) == REG_G2F_NUM_WORDS || cfg_addr_t'(a) == REG_F2G_NUM_WORDS) begin
                wr_vals[a] = wr_vals[a] & 16'hfe00;
            end
            cfg_write(cfg_addr_t'(a), wr_vals[a]);
        end
        for (int a = 0; a < 8; a++) begin
            read_check(cfg_addr_t'(a), wr_vals[a] & field_mask[a]);
        end

        // Host preload and g2f fan-out including a wrapping block
        for (int a = 0; a < BANK_DEPTH; a++) begin
            r = next_random();
            mem_wr_en    = 1'b1;
            mem_wr_addr  = bank_addr_t'(a);
            mem_wr_data  = r[15:0];
            model_mem[a] = r[15:0];
            next_cycle();
        end
        mem_wr_en = 1'b0;
        run_g2f(8'hf8, 16, 2'b11, 2'b00);
        repeat (4) begin
            r = next_random();
            run_g2f(r[7:0], 1 + int'(r[12:8]), r[14:13], 2'b00);
        end

        // f2g capture and a read-back reaching one word past the block
        repeat (3) begin
            r = next_random();
            n = 1 + int'(r[12:8]);
            run_f2g(r[7:0], n, int'(r[13]));
            run_g2f(r[7:0], n + 1, 2'b11, 2'b00);
        end

        // Soft reset routing while a stream runs
        sr_random = 1'b1;
        repeat (3) begin
            r = next_random();
            run_g2f(r[7:0], 1 + int'(r[12:8]), r[14:13],
                    (r[16:15] == 2'b00) ? 2'b01 : r[16:15]);
        end
        sr_random       = 1'b0;
        cgra_soft_reset = 1'b0;

        // Empty masks and zero lengths
        run_g2f(8'h40, 20, 2'b00, 2'b00);
        run_g2f(8'h40, 0, 2'b11, 2'b00);
        run_f2g(8'h40, 0, 1);
        run_g2f(8'h40, 8, 2'b11, 2'b00);

        $display("Errors: data %0d, valid %0d, cfg %0d, mask %0d, other %0d",
                 data_errs, valid_errs, cfg_errs, mask_errs, other_errs);
        if (data_errs + valid_errs + cfg_errs + mask_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
src/glb_pkg.sv
src/glb_cfg_regs.sv
src/glb_bank_mem.sv
src/glb_g2f_dma.sv
src/glb_f2g_dma.sv
src/glb_strm_mux.sv
src/glb_tile.sv
dv/glb_tile_tb.sv

//--- Makefile
BIN := obj_dir/Vglb_tile_tb

.PHONY: all run clean

all: run

$(BIN): sim.f $(wildcard src/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing -j 0 -f sim.f --top-module glb_tile_tb

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
